// File: common/scaler_pkg.sv
package scaler_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths.
  ////////////////////////////////////////////////////////////////////////////
  localparam int PIX_W       = 8;                  // pixel data.
  localparam int COORD_W     = 12;                 // coordinates and sizes.
  localparam int FRAC_W      = 16;                 // ratio fraction.
  localparam int RATIO_W     = COORD_W + FRAC_W;   // 12.16 step ratio.
  localparam int DIV_STEPS   = RATIO_W;            // one quotient bit per cycle.
  localparam int DIV_CNT_W   = $clog2(DIV_STEPS + 1);
  localparam int APB_DW      = 32;
  localparam int APB_AW      = 4;
  localparam int SIZE_HI_LSB = 16;                 // height field in size regs.

  ////////////////////////////////////////////////////////////////////////////
  // register map.
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [APB_AW-1:0] ADDR_SRC_SIZE = 4'h0;  // {h, w}.
  localparam logic [APB_AW-1:0] ADDR_DST_SIZE = 4'h4;  // {h, w}.
  localparam logic [APB_AW-1:0] ADDR_CTRL     = 4'h8;  // bit 0 start.
  localparam logic [APB_AW-1:0] ADDR_STATUS   = 4'hC;  // err, ok, busy.

  ////////////////////////////////////////////////////////////////////////////
  // stream beats and config.
  ////////////////////////////////////////////////////////////////////////////
  // source pixel, one per beat.
  typedef struct packed {
    logic [PIX_W-1:0] data;
    logic             sof;    // first pixel of frame.
  } src_pix_t;

  // kept pixel with its destination position.
  typedef struct packed {
    logic [PIX_W-1:0]   data;
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic               eof;  // last destination pixel.
  } dst_pix_t;

  typedef struct packed {
    logic [COORD_W-1:0] src_w;
    logic [COORD_W-1:0] src_h;
    logic [COORD_W-1:0] dst_w;
    logic [COORD_W-1:0] dst_h;
  } scale_cfg_t;

  // 12.16 steps, one per axis.
  typedef struct packed {
    logic [RATIO_W-1:0] x;
    logic [RATIO_W-1:0] y;
  } ratio_t;

endpackage

// File: src/scaler_regs.sv
`timescale 1ns/10ps

module scaler_regs (
  input  logic                           clk_os,
  input  logic                           i_rst,
  input  logic                           i_psel,
  input  logic                           i_penable,
  input  logic                           i_pwrite,
  input  logic [scaler_pkg::APB_AW-1:0]  i_paddr,
  input  logic [scaler_pkg::APB_DW-1:0]  i_pwdata,
  input  logic                           i_busy,      // divider running.
  input  logic                           i_ratio_ok,
  output logic [scaler_pkg::APB_DW-1:0]  o_prdata,
  output logic                           o_pready,
  output logic                           o_pslverr,
  output scaler_pkg::scale_cfg_t         o_cfg,
  output logic                           o_start
);
  import scaler_pkg::*;

  logic       access;
  logic       size_addr;
  logic       addr_known;
  logic       wr_en;
  logic       size_ok;
  logic       cfg_err;
  scale_cfg_t cfg_q;

  ////////////////////////////////////////////////////////////////////////////
  // decode.
  ////////////////////////////////////////////////////////////////////////////
  assign access     = i_psel & i_penable;   // access phase only.
  assign size_addr  = (i_paddr == ADDR_SRC_SIZE) || (i_paddr == ADDR_DST_SIZE);
  assign addr_known = size_addr || (i_paddr == ADDR_CTRL) || (i_paddr == ADDR_STATUS);

  assign o_pready  = 1'b1;  // zero wait states.
  // bad address, or sizes touched mid divide.
  assign o_pslverr = access & (!addr_known | (i_pwrite & size_addr & i_busy));
  assign wr_en     = access & i_pwrite & !o_pslverr;

  // downscale only, no zero sizes.
  assign size_ok = (cfg_q.dst_w != '0) && (cfg_q.dst_h != '0) &&
                   (cfg_q.dst_w <= cfg_q.src_w) && (cfg_q.dst_h <= cfg_q.src_h);

  assign o_cfg = cfg_q;

  ////////////////////////////////////////////////////////////////////////////
  // config and control.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_os)
  begin
    if (i_rst)
    begin
      cfg_q <= '0;
    end
    else if (wr_en && i_paddr == ADDR_SRC_SIZE)
    begin
      cfg_q.src_w <= i_pwdata[COORD_W-1:0];
      cfg_q.src_h <= i_pwdata[SIZE_HI_LSB +: COORD_W];
    end
    else if (wr_en && i_paddr == ADDR_DST_SIZE)
    begin
      cfg_q.dst_w <= i_pwdata[COORD_W-1:0];
      cfg_q.dst_h <= i_pwdata[SIZE_HI_LSB +: COORD_W];
    end
  end

  always_ff @(posedge clk_os)
  begin
    if (i_rst)
    begin
      o_start <= 1'b0;
      cfg_err <= 1'b0;
    end
    else
    begin
      o_start <= 1'b0;  // single cycle pulse.
      if (wr_en && i_paddr == ADDR_CTRL && i_pwdata[0] && !i_busy && !o_start)
      begin
        if (size_ok)
        begin
          o_start <= 1'b1;
          cfg_err <= 1'b0;  // good config clears old error.
        end
        else
          cfg_err <= 1'b1;  // upscale or zero size.
      end
    end
  end

  // read mux.
  always_comb
  begin
    o_prdata = '0;
    case (i_paddr)
      ADDR_SRC_SIZE:
      begin
        o_prdata[COORD_W-1:0]             = cfg_q.src_w;
        o_prdata[SIZE_HI_LSB +: COORD_W]  = cfg_q.src_h;
      end
      ADDR_DST_SIZE:
      begin
        o_prdata[COORD_W-1:0]             = cfg_q.dst_w;
        o_prdata[SIZE_HI_LSB +: COORD_W]  = cfg_q.dst_h;
      end
      ADDR_STATUS: o_prdata[2:0] = {cfg_err, i_ratio_ok, i_busy};
      default:     o_prdata = '0;  // ctrl reads as zero.
    endcase
  end

  // a new divide never starts over a running one.
  a_start_idle: assert property (@(posedge clk_os) disable iff (i_rst)
    o_start |-> !i_busy);

endmodule

// File: scale/ratio_divider.sv
`timescale 1ns/10ps

module ratio_divider (
  input  logic                   clk_os,
  input  logic                   i_rst,
  input  logic                   i_start,
  input  scaler_pkg::scale_cfg_t i_cfg,
  output logic                   o_busy,
  output logic                   o_ratio_ok,  // held until next start.
  output scaler_pkg::ratio_t     o_ratio
);
  import scaler_pkg::*;

  logic [DIV_CNT_W-1:0]       step_cnt;
  logic                       last_step;
  logic [RATIO_W-1:0]         quo_x;     // dividend shifts out, quotient in.
  logic [RATIO_W-1:0]         quo_y;
  logic [COORD_W-1:0]         rem_x;
  logic [COORD_W-1:0]         rem_y;
  logic [COORD_W+RATIO_W-1:0] nxt_x;
  logic [COORD_W+RATIO_W-1:0] nxt_y;

  // one restoring step. returns {rem, quo}.
  function automatic logic [COORD_W+RATIO_W-1:0] div_step(
    input logic [COORD_W-1:0] rem,
    input logic [RATIO_W-1:0] quo,
    input logic [COORD_W-1:0] dvs
  );
    logic [COORD_W:0] trial;
    logic             qbit;
    trial = {rem, quo[RATIO_W-1]};
    qbit  = (trial >= {1'b0, dvs});
    if (qbit)
      trial = trial - {1'b0, dvs};
    return {trial[COORD_W-1:0], quo[RATIO_W-2:0], qbit};
  endfunction

  // both axes side by side.
  assign nxt_x     = div_step(rem_x, quo_x, i_cfg.dst_w);
  assign nxt_y     = div_step(rem_y, quo_y, i_cfg.dst_h);
  assign last_step = (step_cnt == DIV_CNT_W'(DIV_STEPS));

  always_ff @(posedge clk_os)
  begin
    if (i_rst)
    begin
      o_busy     <= 1'b0;
      o_ratio_ok <= 1'b0;
      step_cnt   <= '0;
    end
    else if (i_start)
    begin
      o_busy     <= 1'b1;
      o_ratio_ok <= 1'b0;  // old ratios are stale.
      step_cnt   <= '0;
    end
    else if (o_busy)
    begin
      if (last_step)
      begin
        o_busy     <= 1'b0;  // rounding cycle done.
        o_ratio_ok <= 1'b1;
      end
      else
        step_cnt <= step_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_os)
  begin
    if (i_start)
    begin
      quo_x <= {i_cfg.src_w, FRAC_W'(0)};  // src << 16.
      quo_y <= {i_cfg.src_h, FRAC_W'(0)};
      rem_x <= '0;
      rem_y <= '0;
    end
    else if (o_busy && !last_step)
    begin
      {rem_x, quo_x} <= nxt_x;
      {rem_y, quo_y} <= nxt_y;
    end
    else if (o_busy)
    begin
      o_ratio.x <= quo_x + 1'b1;  // plus one keeps last target in range.
      o_ratio.y <= quo_y + 1'b1;
    end
  end

  // busy for the steps plus the rounding cycle, then idle.
  a_busy_len: assert property (@(posedge clk_os) disable iff (i_rst)
    i_start |=> o_busy [* DIV_STEPS + 1] ##1 !o_busy);

endmodule

// File: scale/coord_tracker.sv
`timescale 1ns/10ps

module coord_tracker (
  input  logic                   clk_os,
  input  logic                   i_rst,
  input  scaler_pkg::scale_cfg_t i_cfg,
  input  scaler_pkg::ratio_t     i_ratio,
  input  logic                   i_valid,
  input  scaler_pkg::src_pix_t   i_beat,
  input  logic                   i_ready,   // downstream can take.
  output logic                   o_ready,
  output logic                   o_valid,
  output scaler_pkg::dst_pix_t   o_beat
);
  import scaler_pkg::*;

  // raster state.
  logic [COORD_W-1:0] src_x;
  logic [COORD_W-1:0] src_y;
  logic [RATIO_W-1:0] acc_x;     // next kept column, 12.16.
  logic [RATIO_W-1:0] acc_y;     // next kept row.
  logic [COORD_W-1:0] dst_x;
  logic [COORD_W-1:0] dst_y;

  // state seen by this beat, sof forces a fresh frame.
  logic [COORD_W-1:0] cur_x;
  logic [COORD_W-1:0] cur_y;
  logic [RATIO_W-1:0] cur_ax;
  logic [RATIO_W-1:0] cur_ay;
  logic [COORD_W-1:0] cur_dx;
  logic [COORD_W-1:0] cur_dy;

  logic fire;
  logic advance;
  logic row_hit;
  logic col_hit;
  logic keep;
  logic last_col;
  logic last_row;
  logic last_dst;

  assign advance = !o_valid || i_ready;   // stage slot free.
  assign o_ready = advance;
  assign fire    = i_valid && o_ready;

  assign cur_x  = i_beat.sof ? '0 : src_x;
  assign cur_y  = i_beat.sof ? '0 : src_y;
  assign cur_ax = i_beat.sof ? '0 : acc_x;
  assign cur_ay = i_beat.sof ? '0 : acc_y;
  assign cur_dx = i_beat.sof ? '0 : dst_x;
  assign cur_dy = i_beat.sof ? '0 : dst_y;

  ////////////////////////////////////////////////////////////////////////////
  // keep decision.
  ////////////////////////////////////////////////////////////////////////////
  // integer part of the accumulator is the target.
  assign row_hit  = (cur_y == cur_ay[RATIO_W-1:FRAC_W]) && (cur_dy < i_cfg.dst_h);
  assign col_hit  = (cur_x == cur_ax[RATIO_W-1:FRAC_W]) && (cur_dx < i_cfg.dst_w);
  assign keep     = row_hit && col_hit;
  assign last_col = (cur_x == i_cfg.src_w - 1'b1);
  assign last_row = (cur_y == i_cfg.src_h - 1'b1);
  assign last_dst = (cur_dx == i_cfg.dst_w - 1'b1) && (cur_dy == i_cfg.dst_h - 1'b1);

  ////////////////////////////////////////////////////////////////////////////
  // counters and accumulators.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_os)
  begin
    if (i_rst)
    begin
      src_x <= '0;
      src_y <= '0;
      acc_x <= '0;
      acc_y <= '0;
      dst_x <= '0;
      dst_y <= '0;
    end
    else if (fire)
    begin
      if (last_col)
      begin
        src_x <= '0;     // column state restarts each row.
        acc_x <= '0;
        dst_x <= '0;
        if (last_row)
        begin
          src_y <= '0;   // wrap to a new frame.
          acc_y <= '0;
          dst_y <= '0;
        end
        else
        begin
          src_y <= cur_y + 1'b1;
          acc_y <= row_hit ? cur_ay + i_ratio.y : cur_ay;
          dst_y <= row_hit ? cur_dy + 1'b1 : cur_dy;
        end
      end
      else
      begin
        src_x <= cur_x + 1'b1;
        acc_x <= keep ? cur_ax + i_ratio.x : cur_ax;  // step to next target.
        dst_x <= keep ? cur_dx + 1'b1 : cur_dx;
        src_y <= cur_y;  // holds sof clear.
        acc_y <= cur_ay;
        dst_y <= cur_dy;
      end
    end
  end

  // output register, dropped pixels leave a bubble.
  always_ff @(posedge clk_os)
  begin
    if (i_rst)
      o_valid <= 1'b0;
    else if (advance)
      o_valid <= fire && keep;
  end

  always_ff @(posedge clk_os)
  begin
    if (advance)
    begin
      o_beat.data <= i_beat.data;
      o_beat.x    <= cur_dx;
      o_beat.y    <= cur_dy;
      o_beat.eof  <= last_dst;
    end
  end

  // tag never exceeds the programmed width.
  a_dst_x_range: assert property (@(posedge clk_os) disable iff (i_rst)
    o_valid |-> (o_beat.x < i_cfg.dst_w));

endmodule

// File: src/stream_skid.sv
`timescale 1ns/10ps

module stream_skid #(
  parameter type beat_t = logic [7:0]
) (
  input  logic  clk_os,
  input  logic  i_rst,
  input  logic  i_valid,
  input  beat_t i_data,
  input  logic  i_ready,
  output logic  o_ready,
  output logic  o_valid,
  output beat_t o_data
);

  logic  skid_valid;  // second entry, holds a beat caught during a stall.
  beat_t skid_data;
  logic  out_free;

  assign o_ready  = !skid_valid;         // straight from a flop.
  assign out_free = !o_valid || i_ready; // output slot drains this cycle.

  always_ff @(posedge clk_os)
  begin
    if (i_rst)
    begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end
    else if (out_free)
    begin
      o_valid    <= skid_valid || i_valid;  // skid first, keeps order.
      skid_valid <= 1'b0;
    end
    else if (i_valid && o_ready)
      skid_valid <= 1'b1;                   // park the beat.
  end

  always_ff @(posedge clk_os)
  begin
    if (out_free)
      o_data <= skid_valid ? skid_data : i_data;
    if (!out_free && i_valid && o_ready)
      skid_data <= i_data;
  end

  // stalled beat holds.
  a_hold: assert property (@(posedge clk_os) disable iff (i_rst)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule

// File: src/nn_scaler_top.sv
`timescale 1ns/10ps

module nn_scaler_top (
  input  logic                          clk_os,
  input  logic                          i_rst,
  // apb slave.
  input  logic                          i_psel,
  input  logic                          i_penable,
  input  logic                          i_pwrite,
  input  logic [scaler_pkg::APB_AW-1:0] i_paddr,
  input  logic [scaler_pkg::APB_DW-1:0] i_pwdata,
  output logic [scaler_pkg::APB_DW-1:0] o_prdata,
  output logic                          o_pready,
  output logic                          o_pslverr,
  // source pixels.
  input  logic                          i_src_valid,
  output logic                          o_src_ready,
  input  scaler_pkg::src_pix_t          i_src,
  // kept pixels.
  output logic                          o_dst_valid,
  input  logic                          i_dst_ready,
  output scaler_pkg::dst_pix_t          o_dst
);
  import scaler_pkg::*;

  scale_cfg_t cfg;
  ratio_t     ratio;
  logic       start;
  logic       busy;
  logic       ratio_ok;

  logic       src_valid_ok;   // stream held off until ratios are ready.
  logic       src_skid_ready;
  logic       trk_in_valid;
  logic       trk_in_ready;
  src_pix_t   trk_in_beat;
  logic       trk_out_valid;
  logic       trk_out_ready;
  dst_pix_t   trk_out_beat;

  assign src_valid_ok = i_src_valid & ratio_ok;
  assign o_src_ready  = src_skid_ready & ratio_ok;

  scaler_regs regs0 (
    .clk_os(clk_os), .i_rst(i_rst),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .i_busy(busy), .i_ratio_ok(ratio_ok),
    .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
    .o_cfg(cfg), .o_start(start)
  );

  ratio_divider div0 (
    .clk_os(clk_os), .i_rst(i_rst), .i_start(start), .i_cfg(cfg),
    .o_busy(busy), .o_ratio_ok(ratio_ok), .o_ratio(ratio)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pixel path. skid, tracker, skid.
  ////////////////////////////////////////////////////////////////////////////
  stream_skid #(.beat_t(src_pix_t)) skid_in0 (
    .clk_os(clk_os), .i_rst(i_rst),
    .i_valid(src_valid_ok), .i_data(i_src), .o_ready(src_skid_ready),
    .o_valid(trk_in_valid), .o_data(trk_in_beat), .i_ready(trk_in_ready)
  );

  coord_tracker trk0 (
    .clk_os(clk_os), .i_rst(i_rst), .i_cfg(cfg), .i_ratio(ratio),
    .i_valid(trk_in_valid), .i_beat(trk_in_beat), .o_ready(trk_in_ready),
    .o_valid(trk_out_valid), .o_beat(trk_out_beat), .i_ready(trk_out_ready)
  );

  stream_skid #(.beat_t(dst_pix_t)) skid_out0 (
    .clk_os(clk_os), .i_rst(i_rst),
    .i_valid(trk_out_valid), .i_data(trk_out_beat), .o_ready(trk_out_ready),
    .o_valid(o_dst_valid), .o_data(o_dst), .i_ready(i_dst_ready)
  );

endmodule

// File: tb/tb_nn_scaler.sv
`timescale 1ns/10ps

module tb_nn_scaler;
  import scaler_pkg::*;

  // src pixels x 4 + 100 per frame.
  localparam int TIMEOUT_CYC = 2 * (192 * 4 + 100) + (100 * 4 + 100) + (37 * 4 + 100) +
                               (91 * 4 + 100);

  logic              clk_os;
  logic              i_rst;
  logic              i_psel;
  logic              i_penable;
  logic              i_pwrite;
  logic [APB_AW-1:0] i_paddr;
  logic [APB_DW-1:0] i_pwdata;
  logic [APB_DW-1:0] o_prdata;
  logic              o_pready;
  logic              o_pslverr;
  logic              i_src_valid;
  logic              o_src_ready;
  src_pix_t          i_src;
  logic              o_dst_valid;
  logic              i_dst_ready;
  dst_pix_t          o_dst;

  dst_pix_t    exp_q[$];    // model output in raster order.
  dst_pix_t    exp_head;
  logic        exp_avail;
  logic        rd_chk;      // compare read data this access.
  logic        err_exp;
  logic [31:0] rd_exp;
  logic [31:0] rdata;
  logic        stall_en;
  logic [7:0]  pix [0:255];  // current source frame.
  int          err_cnt;
  int          frame_cnt;
  int          beat_total;
  int unsigned cyc_cnt = 0;

  nn_scaler_top dut0 (.*);

  initial
  begin
    clk_os = 1'b0;
    forever #4 clk_os = ~clk_os;
  end

  always @(posedge clk_os) cyc_cnt <= cyc_cnt + 1;

  initial
  begin
    wait (cyc_cnt == TIMEOUT_CYC);
    $display("timeout: run still busy after %0d cycles", TIMEOUT_CYC);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // sink back-pressure.
  always @(negedge clk_os)
    i_dst_ready = stall_en ? ($urandom_range(3) != 0) : 1'b1;

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    err_cnt++;
    $display("ERR %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
  endtask

  task automatic refresh_head();
    exp_avail = (exp_q.size() != 0);
    exp_head  = exp_avail ? exp_q[0] : '0;
  endtask

  // assertions sample the head before this pop.
  always @(posedge clk_os)
  begin
    if (!i_rst && o_dst_valid && i_dst_ready)
    begin
      frame_cnt++;
      beat_total++;
      if (exp_q.size() != 0)
        void'(exp_q.pop_front());
      refresh_head();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks.
  ////////////////////////////////////////////////////////////////////////////
  // slave never inserts wait states.
  a_apb_ready: assert property (@(posedge clk_os) disable iff (i_rst)
    (i_psel && i_penable) |-> o_pready)
    else report_mismatch("o_pready", 32'h1, 32'($sampled(o_pready)));
  a_apb_err: assert property (@(posedge clk_os) disable iff (i_rst)
    (i_psel && i_penable) |-> (o_pslverr == err_exp))
    else report_mismatch("o_pslverr", 32'($sampled(err_exp)), 32'($sampled(o_pslverr)));
  a_apb_rd: assert property (@(posedge clk_os) disable iff (i_rst)
    (i_psel && i_penable && rd_chk) |-> (o_prdata == rd_exp))
    else report_mismatch("o_prdata", $sampled(rd_exp), $sampled(o_prdata));
  // no pixels taken before the ratios exist.
  a_src_hold: assert property (@(posedge clk_os) disable iff (i_rst)
    (i_psel && i_penable && !i_pwrite && i_paddr == ADDR_STATUS && !o_prdata[1])
    |-> !o_src_ready)
    else report_mismatch("o_src_ready", 32'h0, 32'($sampled(o_src_ready)));
  a_dst_extra: assert property (@(posedge clk_os) disable iff (i_rst)
    (o_dst_valid && i_dst_ready) |-> exp_avail)
    else
    begin
      err_cnt++;
      $display("output beat arrived with no expected pixel left at %0t", $time);
    end
  a_dst_data: assert property (@(posedge clk_os) disable iff (i_rst)
    (o_dst_valid && i_dst_ready && exp_avail) |-> (o_dst.data == exp_head.data))
    else report_mismatch("o_dst.data", 32'($sampled(exp_head.data)), 32'($sampled(o_dst.data)));
  a_dst_x: assert property (@(posedge clk_os) disable iff (i_rst)
    (o_dst_valid && i_dst_ready && exp_avail) |-> (o_dst.x == exp_head.x))
    else report_mismatch("o_dst.x", 32'($sampled(exp_head.x)), 32'($sampled(o_dst.x)));
  a_dst_y: assert property (@(posedge clk_os) disable iff (i_rst)
    (o_dst_valid && i_dst_ready && exp_avail) |-> (o_dst.y == exp_head.y))
    else report_mismatch("o_dst.y", 32'($sampled(exp_head.y)), 32'($sampled(o_dst.y)));
  a_dst_eof: assert property (@(posedge clk_os) disable iff (i_rst)
    (o_dst_valid && i_dst_ready && exp_avail) |-> (o_dst.eof == exp_head.eof))
    else report_mismatch("o_dst.eof", 32'($sampled(exp_head.eof)), 32'($sampled(o_dst.eof)));

  ////////////////////////////////////////////////////////////////////////////
  // drivers and model.
  ////////////////////////////////////////////////////////////////////////////
  // setup, access, idle. wdata doubles as expected read data.
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                            input logic chk, input logic exp_err);
    @(negedge clk_os);
    i_psel   = 1'b1;
    i_pwrite = wr;
    i_paddr  = addr;
    i_pwdata = data;
    rd_exp   = data;
    rd_chk   = chk;
    err_exp  = exp_err;
    @(negedge clk_os);
    i_penable = 1'b1;
    @(negedge clk_os);
    rdata     = o_prdata;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    rd_chk    = 1'b0;
  endtask

  task automatic configure_scaler(input int sw, input int sh, input int dw, input int dh);
    logic [31:0] src_word;
    logic [31:0] dst_word;
    int          tries;
    src_word = (sh << 16) | sw;
    dst_word = (dh << 16) | dw;
    apb_access(1'b1, ADDR_SRC_SIZE, src_word, 1'b0, 1'b0);
    apb_access(1'b1, ADDR_DST_SIZE, dst_word, 1'b0, 1'b0);
    apb_access(1'b0, ADDR_SRC_SIZE, src_word, 1'b1, 1'b0);   // readback.
    apb_access(1'b0, ADDR_DST_SIZE, dst_word, 1'b1, 1'b0);
    apb_access(1'b1, ADDR_CTRL, 32'h1, 1'b0, 1'b0);
    apb_access(1'b1, ADDR_SRC_SIZE, src_word, 1'b0, 1'b1);   // refused while busy.
    apb_access(1'b0, ADDR_STATUS, 32'h1, 1'b1, 1'b0);        // busy only.
    tries = 0;
    do
    begin
      apb_access(1'b0, ADDR_STATUS, 32'h0, 1'b0, 1'b0);
      tries++;
    end
    while (!rdata[1] && tries < 64);
    if (!rdata[1])
    begin
      err_cnt++;
      $display("ratios never became valid after start");
    end
    apb_access(1'b0, ADDR_STATUS, 32'h2, 1'b1, 1'b0);        // ratios valid and idle.
  endtask

  // destination index j maps to source (j * ratio) >> 16.
  task automatic build_expected(input int sw, input int sh, input int dw, input int dh,
                                input int npix);
    int rx;
    int ry;
    int sx;
    int sy;
    rx = ((sw << 16) / dw) + 1;
    ry = ((sh << 16) / dh) + 1;
    for (int dy = 0; dy < dh; dy++)
    begin
      sy = (dy * ry) >> 16;
      for (int dx = 0; dx < dw; dx++)
      begin
        sx = (dx * rx) >> 16;
        if (sy * sw + sx < npix)  // only pixels that are sent.
          exp_q.push_back('{data: pix[sy * sw + sx], x: 12'(dx), y: 12'(dy),
                            eof: (dx == dw - 1 && dy == dh - 1)});
      end
    end
    refresh_head();
  endtask

  task automatic run_frame(input int sw, input int sh, input int dw, input int dh,
                           input logic stall, input int npix);
    int exp_cnt;
    stall_en  = stall;
    frame_cnt = 0;
    for (int i = 0; i < sw * sh; i++)
      pix[i] = 8'($urandom_range(255));
    build_expected(sw, sh, dw, dh, npix);
    exp_cnt = exp_q.size();
    for (int i = 0; i < npix; i++)
    begin
      i_src_valid = 1'b1;
      i_src.data  = pix[i];
      i_src.sof   = (i == 0);
      while (!o_src_ready)
        @(negedge clk_os);  // ready comes from a flop.
      @(negedge clk_os);
    end
    i_src_valid = 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk_os);
    repeat (4) @(negedge clk_os);  // late extra beats.
    assert (frame_cnt == exp_cnt)
      else report_mismatch("frame output count", 32'(exp_cnt), 32'(frame_cnt));
  endtask

  initial
  begin
    void'($urandom(32'ha532_dd6c));
    i_rst       = 1'b1;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    i_src_valid = 1'b0;
    i_src       = '0;
    i_dst_ready = 1'b1;
    stall_en    = 1'b0;
    rd_chk      = 1'b0;
    err_exp     = 1'b0;
    rd_exp      = '0;
    err_cnt     = 0;
    frame_cnt   = 0;
    beat_total  = 0;
    refresh_head();
    repeat (2) @(negedge clk_os);
    i_rst = 1'b0;

    apb_access(1'b0, ADDR_STATUS, 32'h0, 1'b1, 1'b0);   // all clear out of reset.
    apb_access(1'b0, 4'h2, 32'h0, 1'b1, 1'b1);          // unknown address.
    apb_access(1'b1, 4'h6, 32'h5, 1'b0, 1'b1);
    // upscale request sets the error bit and starts nothing.
    apb_access(1'b1, ADDR_SRC_SIZE, 32'h0008_0008, 1'b0, 1'b0);
    apb_access(1'b1, ADDR_DST_SIZE, 32'h0004_0009, 1'b0, 1'b0);
    apb_access(1'b1, ADDR_CTRL, 32'h1, 1'b0, 1'b0);
    apb_access(1'b0, ADDR_STATUS, 32'h4, 1'b1, 1'b0);

    configure_scaler(16, 12, 8, 5);
    run_frame(16, 12, 8, 5, 1'b0, 192);
    run_frame(16, 12, 8, 5, 1'b1, 192);
    configure_scaler(10, 10, 10, 10);
    run_frame(10, 10, 10, 10, 1'b1, 100);
    run_frame(10, 10, 10, 10, 1'b1, 37);   // frame cut short mid row.
    configure_scaler(13, 7, 6, 3);   // realign on new sizes.
    run_frame(13, 7, 6, 3, 1'b1, 91);

    $display("errors: %0d, output beats seen: %0d", err_cnt, beat_total);
    if (err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: nn_scaler_top.f
common/scaler_pkg.sv
src/scaler_regs.sv
scale/ratio_divider.sv
scale/coord_tracker.sv
src/stream_skid.sv
src/nn_scaler_top.sv
tb/tb_nn_scaler.sv

// File: Makefile
# Verilator flow for the nearest-neighbour downscaler.

TB    = tb_nn_scaler
FLIST = nn_scaler_top.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module nn_scaler_top -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TB) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TB) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
